/* Makefile */
TOP := tb_uart_echo

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f vlog.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* hdl/string_echo_ctrl.sv */
// echo controller
// byte buffer with payload limit, quiet-gap timer,
// FSM that sends the buffer plus "&&" one byte per tx_done

`include "uart_echo_cfg.svh"

module string_echo_ctrl (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  uart_echo_pkg::byte_t rx_data,
	input  logic                 rx_vld,
	input  logic                 tx_done,
	output uart_echo_pkg::byte_t tx_data,
	output logic                 tx_req,
	output logic                 echo_busy
);
	import uart_echo_pkg::*;

	localparam int DEPTH       = `ECHO_BUF_DEPTH;
	localparam int MAX_PAYLOAD = DEPTH - 2;
	localparam int ADDR_W      = $clog2(DEPTH);
	localparam int PTR_W       = ADDR_W + 1;
	localparam int GAP_W       = $clog2(`ECHO_GAP_CLKS);
	localparam byte_t MARKER   = 8'h26;

	echo_state_t       state;
	byte_t             buf_mem [DEPTH];
	logic [PTR_W-1:0]  wr_cnt;
	logic [PTR_W-1:0]  rd_cnt;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	logic [GAP_W-1:0]  gap_cnt;
	logic              store;
	logic              gap_done;
	logic              last_done;
	logic              load;

	assign wr_addr = wr_cnt[ADDR_W-1:0];
	assign rd_addr = rd_cnt[ADDR_W-1:0];

	// bytes past the payload limit are dropped
	assign store = rx_vld && (state == idle || state == collect)
	             && (wr_cnt < PTR_W'(MAX_PAYLOAD));

	// a byte in the final gap cycle still restarts the timer
	assign gap_done = (state == collect) && !rx_vld
	                && (gap_cnt == GAP_W'(`ECHO_GAP_CLKS - 1));

	// rd_cnt has passed every stored byte, markers included
	assign last_done = (state == send) && tx_done && (rd_cnt == wr_cnt);

	// fetch next byte for the transmitter
	assign load = gap_done || ((state == send) && tx_done && !last_done);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= idle;
		end else begin
			case (state)
				idle:    if (rx_vld) state <= collect;
				collect: if (gap_done) state <= send;
				send:    if (last_done) state <= mark;
				mark:    state <= finish;
				finish:  state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// quiet gap timer, runs only while collecting
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			gap_cnt <= '0;
		else if (state != collect || rx_vld)
			gap_cnt <= '0;
		else
			gap_cnt <= gap_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_cnt <= '0;
			rd_cnt <= '0;
			tx_req <= 1'b0;
		end else begin
			tx_req <= load;
			if (store)
				wr_cnt <= wr_cnt + 1'b1;
			else if (gap_done)
				wr_cnt <= wr_cnt + PTR_W'(2);
			else if (state == finish)
				wr_cnt <= '0;

			if (load)
				rd_cnt <= rd_cnt + 1'b1;
			else if (state == finish)
				rd_cnt <= '0;
		end
	end

	// buffer writes, markers go right after the payload
	always_ff @(posedge sys_clk) begin
		if (store)
			buf_mem[wr_addr] <= rx_data;
		if (gap_done) begin
			buf_mem[wr_addr]        <= MARKER;
			buf_mem[wr_addr + 1'b1] <= MARKER;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load)
			tx_data <= buf_mem[rd_addr];
	end

	// high from the first tx_req through finish
	assign echo_busy = (state == send) || (state == mark) || (state == finish);

endmodule

/* hdl/uart_echo_pkg.sv */
// shared types for the UART echo unit
// data byte type and controller state enum

package uart_echo_pkg;

	// one serial data byte
	typedef logic [7:0] byte_t;

	// echo controller states
	typedef enum logic [2:0] {
		idle,
		collect,
		send,
		mark,
		finish
	} echo_state_t;

endpackage

/* hdl/uart_echo_top.sv */
// UART string echo unit, top level
// receiver -> echo controller -> transmitter

module uart_echo_top (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic uart_rx_port,
	output logic uart_tx_port,
	output logic echo_busy
);
	import uart_echo_pkg::*;

	byte_t rx_data;
	logic  rx_vld;
	byte_t tx_data;
	logic  tx_req;
	logic  tx_done;

	// serial in
	uart_rx i_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld)
	);

	string_echo_ctrl i_string_echo_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.tx_done   (tx_done),
		.tx_data   (tx_data),
		.tx_req    (tx_req),
		.echo_busy (echo_busy)
	);

	// serial out, idles high
	uart_tx i_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_req    (tx_req),
		.tx        (uart_tx_port),
		.tx_done   (tx_done)
	);

endmodule

/* hdl/uart_rx.sv */
// UART receiver, 8N1, LSB first
// two-flop line synchronizer, start bit check at half bit,
// data sampling at bit centers, one-cycle rx_vld on a good stop bit

`include "uart_echo_cfg.svh"

module uart_rx (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 rx,
	output uart_echo_pkg::byte_t rx_data,
	output logic                 rx_vld
);
	import uart_echo_pkg::*;

	localparam int CLKS  = `UART_CLKS_PER_BIT;
	localparam int HALF  = CLKS / 2;
	localparam int CNT_W = $clog2(CLKS);

	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_cnt;
	logic             bit_tick;
	byte_t            shift_reg;

	// line synchronizer plus one more stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// start bit is checked at half a bit, later bits one full bit apart
	assign bit_tick = (bit_cnt == 4'd0) ? (clk_cnt == CNT_W'(HALF - 1))
	                                    : (clk_cnt == CNT_W'(CLKS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= 4'd0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			if (!busy) begin
				// falling edge on an idle line
				if (rx_prev && !rx_sync) begin
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_cnt <= 4'd0;
				end
			end else if (bit_tick) begin
				clk_cnt <= '0;
				if (bit_cnt == 4'd0 && rx_sync) begin
					// glitch, not a real start bit
					busy <= 1'b0;
				end else if (bit_cnt == 4'd9) begin
					busy   <= 1'b0;
					// framing error gives no pulse
					rx_vld <= rx_sync;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// data bits shift in from the top, LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (busy && bit_tick && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end

	assign rx_data = shift_reg;

endmodule

/* hdl/uart_tx.sv */
// UART transmitter, 8N1, LSB first
// latches a byte on tx_req, sends start, data and stop bits,
// pulses tx_done in the last cycle of the stop bit

`include "uart_echo_cfg.svh"

module uart_tx (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  uart_echo_pkg::byte_t tx_data,
	input  logic                 tx_req,
	output logic                 tx,
	output logic                 tx_done
);
	import uart_echo_pkg::*;

	localparam int CLKS  = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS);

	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_cnt;
	logic             bit_end;
	// data bits followed by the stop bit
	logic [8:0]       shift_reg;

	assign bit_end = busy && (clk_cnt == CNT_W'(CLKS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= 4'd0;
			tx      <= 1'b1;
		end else begin
			if (!busy) begin
				if (tx_req) begin
					// start bit goes out from the next cycle
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_cnt <= 4'd0;
					tx      <= 1'b0;
				end
			end else if (bit_end) begin
				clk_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
					tx   <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					tx      <= shift_reg[0];
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!busy && tx_req)
			shift_reg <= {1'b1, tx_data};
		else if (bit_end)
			shift_reg <= {1'b1, shift_reg[8:1]};
	end

	// last cycle of the stop bit
	assign tx_done = bit_end && (bit_cnt == 4'd9);

endmodule

/* include/uart_echo_cfg.svh */
// timing and size constants for the UART echo unit
// bit time, quiet gap before an echo, buffer depth

`ifndef UART_ECHO_CFG_SVH
`define UART_ECHO_CFG_SVH

// sys_clk cycles per serial bit
`define UART_CLKS_PER_BIT 16

// quiet cycles after the last byte before the echo starts
// must exceed one frame (10 bits)
`define ECHO_GAP_CLKS 400

// buffer size in bytes, two of them reserved for the markers
`define ECHO_BUF_DEPTH 64

`endif

/* test/echo_cases.txt */
# columns: name, byte count, then that many hex bytes or the word rand
# only the first 62 bytes of a message come back, followed by 26 26
single_byte    1  41
hello          5  48 65 6c 6c 6f
marker_char    3  26 00 ff
random_short  12  rand
all_ones       4  ff ff ff ff
random_full   62  rand
random_long   70  rand
second_msg     2  0d 0a

/* test/tb_uart_echo.sv */
// testbench for the UART string echo unit
// reads cases from a data file, drives serial frames, decodes the echo,
// checks bytes, markers, gap timing and the quiet line afterwards

`include "uart_echo_cfg.svh"

module tb_uart_echo;
	import uart_echo_pkg::*;

	localparam int CLKS        = `UART_CLKS_PER_BIT;
	localparam int FRAME       = 10 * CLKS;
	localparam int GAP         = `ECHO_GAP_CLKS;
	localparam int MAX_PAYLOAD = `ECHO_BUF_DEPTH - 2;
	localparam byte_t MARKER    = 8'h26;
	localparam byte_t LATE_BYTE = 8'h5a;

	logic sys_clk;
	logic sys_rst_n;
	logic uart_rx_port;
	logic uart_tx_port;
	logic echo_busy;

	int          cycle_cnt;
	int          cycle_limit;
	logic [15:0] lfsr_state;
	string       case_name [$];
	int          case_count [$];
	int          case_first [$];
	byte_t       stim_bytes [$];

	uart_echo_top i_uart_echo_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port),
		.echo_busy    (echo_busy)
	);

	always #20 sys_clk = ~sys_clk;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_equal(input string test_name, input int expected, input int actual);
		if (expected != actual)
			fail_run($sformatf("MISMATCH %s: expected 0x%0h, actual 0x%0h",
				test_name, expected, actual));
	endtask

	// cycle counter and watchdog
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
			fail_run("timeout: the echo never completed within the cycle limit");
	end

	// 16-bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hb400;
		return s >> 1;
	endfunction

	task automatic next_rand_byte(output byte_t b);
		int i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			b[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic bit is_space(input byte c);
		return c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d;
	endfunction

	function automatic string next_token(input string s, inout int pos);
		int start;
		while (pos < s.len() && is_space(s[pos]))
			pos++;
		start = pos;
		while (pos < s.len() && !is_space(s[pos]))
			pos++;
		if (pos == start)
			return "";
		return s.substr(start, pos - 1);
	endfunction

	task automatic load_cases();
		int    fd;
		int    code;
		int    pos;
		int    count;
		int    i;
		bit    is_rand;
		string line;
		string tok;
		string name;
		byte_t b;
		fd = $fopen("test/echo_cases.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open the case file test/echo_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				pos = 0;
				name = next_token(line, pos);
				// skip blank and comment lines
				if (code > 0 && name != "" && name[0] != 8'h23) begin
					tok = next_token(line, pos);
					count = tok.atoi();
					case_name.push_back(name);
					case_count.push_back(count);
					case_first.push_back(stim_bytes.size());
					tok = next_token(line, pos);
					is_rand = (tok == "rand");
					for (i = 0; i < count; i++) begin
						if (is_rand) begin
							next_rand_byte(b);
						end else begin
							if (i > 0)
								tok = next_token(line, pos);
							if (tok == "")
								fail_run({"case ", name, " lists fewer bytes than its count"});
							b = byte_t'(tok.atohex());
						end
						stim_bytes.push_back(b);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// one 8N1 frame sent LSB first
	task automatic send_frame(input byte_t b, output int stop_center);
		logic [9:0] bits;
		int         i;
		bits = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			uart_rx_port <= bits[i];
			if (i == 9)
				stop_center = cycle_cnt + CLKS / 2;
			repeat (CLKS - 1) @(posedge sys_clk);
		end
	endtask

	// waits for a start bit and samples at bit centers
	task automatic receive_frame(output byte_t b, output int start_cycle);
		int i;
		b = '0;
		@(negedge sys_clk);
		while (uart_tx_port)
			@(negedge sys_clk);
		start_cycle = cycle_cnt;
		repeat (CLKS / 2) @(negedge sys_clk);
		if (uart_tx_port)
			fail_run("echo start bit did not stay low to its center");
		for (i = 0; i < 8; i++) begin
			repeat (CLKS) @(negedge sys_clk);
			b[i] = uart_tx_port;
		end
		repeat (CLKS) @(negedge sys_clk);
		if (!uart_tx_port)
			fail_run("echo frame has a low stop bit");
	endtask

	task automatic run_case(input int idx);
		string name;
		int    count;
		int    first;
		int    n_exp;
		int    stop_center;
		int    late_center;
		int    first_start;
		int    start_c;
		int    i;
		int    j;
		int    k;
		byte_t b;
		byte_t exp_q [$];
		byte_t act_q [$];
		name = case_name[idx];
		count = case_count[idx];
		first = case_first[idx];
		n_exp = (count < MAX_PAYLOAD) ? count : MAX_PAYLOAD;
		for (i = 0; i < n_exp; i++)
			exp_q.push_back(stim_bytes[first + i]);
		exp_q.push_back(MARKER);
		exp_q.push_back(MARKER);
		fork
			begin
				for (j = 0; j < count; j++)
					send_frame(stim_bytes[first + j], stop_center);
				// one extra byte during the echo that must be dropped
				@(negedge sys_clk);
				while (!echo_busy)
					@(negedge sys_clk);
				send_frame(LATE_BYTE, late_center);
			end
			begin
				for (k = 0; k < exp_q.size(); k++) begin
					receive_frame(b, start_c);
					if (k == 0) begin
						first_start = start_c;
						check_equal({name, " busy at first echo bit"}, 1, int'(echo_busy));
					end
					act_q.push_back(b);
				end
			end
		join
		if (first_start - stop_center < GAP)
			fail_run($sformatf("%s: echo began %0d cycles after the last stop bit, %s",
				name, first_start - stop_center, "sooner than the quiet gap"));
		for (i = 0; i < exp_q.size(); i++)
			check_equal($sformatf("%s byte %0d", name, i), int'(exp_q[i]), int'(act_q[i]));
		// nothing more goes out after the markers
		while (echo_busy) begin
			@(negedge sys_clk);
			check_equal({name, " tx line after markers"}, 1, int'(uart_tx_port));
		end
		if (cycle_cnt < late_center + CLKS)
			fail_run($sformatf("%s: echo ended before the late byte was received", name));
		// no second echo may follow
		repeat (2 * GAP) begin
			@(negedge sys_clk);
			check_equal({name, " busy after echo"}, 0, int'(echo_busy));
			check_equal({name, " tx line after echo"}, 1, int'(uart_tx_port));
		end
	endtask

	initial begin
		int c;
		int limit;
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		uart_rx_port = 1'b1;
		cycle_cnt = 0;
		cycle_limit = 0;
		lfsr_state = 16'h0001;
		load_cases();
		if (case_name.size() == 0)
			fail_run("the case file holds no cases");
		limit = 0;
		for (c = 0; c < case_name.size(); c++)
			limit += (case_count[c] + 2) * 2 * FRAME + GAP + 2000;
		cycle_limit = limit;
		repeat (8) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		// quiet outputs after reset
		repeat (50) begin
			@(negedge sys_clk);
			check_equal("after_reset busy", 0, int'(echo_busy));
			check_equal("after_reset tx line", 1, int'(uart_tx_port));
		end
		for (c = 0; c < case_name.size(); c++)
			run_case(c);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* test/uart_echo_checker.sv */
// concurrent assertions for the UART echo top level
// idle transmit line, one request per frame, single-cycle rx_vld

module uart_echo_checker (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic rx_vld,
	input logic tx_req,
	input logic tx_done,
	input logic uart_tx_port,
	input logic echo_busy
);

	// set by a request, cleared when its frame is done
	logic tx_in_flight;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			tx_in_flight <= 1'b0;
		else if (tx_req)
			tx_in_flight <= 1'b1;
		else if (tx_done)
			tx_in_flight <= 1'b0;
	end

	tx_idle_outside_echo: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		!echo_busy |-> uart_tx_port
	) else $error("transmit line low while no echo is running");

	no_req_during_frame: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_in_flight |-> !tx_req
	) else $error("tx_req issued before the previous tx_done");

	rx_vld_single_cycle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_vld |=> !rx_vld
	) else $error("rx_vld high for two cycles in a row");

endmodule

bind uart_echo_top uart_echo_checker i_uart_echo_checker (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.rx_vld       (rx_vld),
	.tx_req       (tx_req),
	.tx_done      (tx_done),
	.uart_tx_port (uart_tx_port),
	.echo_busy    (echo_busy)
);

/* vlog.f */
+incdir+include
hdl/uart_echo_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/string_echo_ctrl.sv
hdl/uart_echo_top.sv
test/uart_echo_checker.sv
test/tb_uart_echo.sv
